/* Makefile */
# Verilator build and run of the EX-to-WB pipeline testbench
# override any variable on the command line, e.g. make run LOG=other.log

VERILATOR ?= verilator
TOP ?= tb_ex_wb_pipe
LOG ?= sim.log
FLAGS ?= --binary --timing --assert

FILELIST := compile.f
SRCS := $(shell grep -v '^+' $(FILELIST))
BIN := obj_dir/V$(TOP)

.PHONY: all run clean

all: $(BIN)

# rebuilt only when a source or the file list changes
$(BIN): $(FILELIST) $(SRCS)
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

# the log decides pass or fail
run: $(BIN)
	./$(BIN) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -qx "all tests passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

/* alu.sv */
// ============================
// combinational ALU for the execute stage
// op selects the function, zero flags an all-zero result
// ============================

`timescale 1ns/1ps

module alu
	import cpu_pkg::*;
#(
	parameter int DATA_W = 32
) (
	input aluop_t op,
	input logic [DATA_W-1:0] a,
	input logic [DATA_W-1:0] b,
	input logic [4:0] shamt,
	output logic [DATA_W-1:0] result,
	output logic zero
);

	localparam int HALF_W = DATA_W / 2;

	always_comb begin
		case (op)
			ALU_ADD: result = a + b;
			ALU_SUB: result = a - b;
			ALU_AND: result = a & b;
			ALU_OR:  result = a | b;
			ALU_XOR: result = a ^ b;
			// signed compare, result is 0 or 1
			ALU_SLT: result = {{(DATA_W-1){1'b0}}, ($signed(a) < $signed(b))};
			// shift amount comes from the instruction, not a register
			ALU_SLL: result = b << shamt;
			// immediate sits in the low half of b
			ALU_LUI: result = {b[HALF_W-1:0], {HALF_W{1'b0}}};
			default: result = '0;
		endcase
	end

	assign zero = (result == '0);

endmodule

/* compile.f */
cpu_pkg.sv
alu.sv
ex_stage.sv
ex_mem_reg.sv
mem_stage.sv
mem_wb_reg.sv
ex_wb_pipe.sv
ex_wb_pipe_assertions.sv
tb_ex_wb_pipe.sv

/* cpu_pkg.sv */
// ============================
// shared types for the EX-to-WB pipeline slice
// opcode, funct and ALU encodings plus the instruction word
// import with cpu_pkg::* in the module header
// ============================

package cpu_pkg;

	typedef logic [31:0] word_t;
	typedef logic [4:0] regbits_t;

	// MIPS primary opcodes that this slice executes
	typedef enum logic [5:0] {
		OP_RTYPE = 6'h00,
		OP_ADDIU = 6'h09,
		OP_SLTI  = 6'h0A,
		OP_ORI   = 6'h0D,
		OP_LUI   = 6'h0F,
		OP_LW    = 6'h23,
		OP_SW    = 6'h2B
	} opcode_t;

	// R-type function codes
	typedef enum logic [5:0] {
		FN_SLL  = 6'h00,
		FN_ADDU = 6'h21,
		FN_SUBU = 6'h23,
		FN_AND  = 6'h24,
		FN_OR   = 6'h25,
		FN_XOR  = 6'h26,
		FN_SLT  = 6'h2A
	} funct_t;

	typedef enum logic [3:0] {
		ALU_ADD = 4'd0,
		ALU_SUB = 4'd1,
		ALU_AND = 4'd2,
		ALU_OR  = 4'd3,
		ALU_XOR = 4'd4,
		ALU_SLT = 4'd5,
		ALU_SLL = 4'd6,
		ALU_LUI = 4'd7
	} aluop_t;

	// which instruction field names the write register
	typedef enum logic {
		SEL_RD = 1'b0,
		SEL_RT = 1'b1
	} reg_dest_sel_t;

	typedef struct packed {
		opcode_t opcode;
		regbits_t rs;
		regbits_t rt;
		regbits_t rd;
		logic [4:0] shamt;
		funct_t funct;
	} rtype_t;

	typedef struct packed {
		opcode_t opcode;
		regbits_t rs;
		regbits_t rt;
		logic [15:0] imm16;
	} itype_t;

	// same 32 bits, read as R or I format depending on opcode
	typedef union packed {
		rtype_t rtype;
		itype_t itype;
	} instr_u;

endpackage

/* ex_mem_reg.sv */
// ============================
// EX/MEM pipeline register
// loads when enabled, takes a bubble on flush, holds otherwise
// reset also leaves a bubble
// ============================

`timescale 1ns/1ps

module ex_mem_reg
	import cpu_pkg::*;
#(
	parameter int DATA_W = 32
) (
	input logic CLK,
	input logic nRST,
	input logic enable,
	input logic flush,
	input logic [DATA_W-1:0] result,
	input logic [DATA_W-1:0] store_data,
	input regbits_t wsel,
	input logic ex_wen,
	input logic ex_dren,
	input logic ex_dwen,
	input logic ex_halt,
	output logic [DATA_W-1:0] dmemaddr,
	output logic [DATA_W-1:0] dmemstore,
	output logic [DATA_W-1:0] result_ex_mem,
	output regbits_t wsel_ex_mem,
	output logic wen_ex_mem,
	output logic dren,
	output logic dwen,
	output logic halt_ex_mem
);

	logic [DATA_W-1:0] result_reg, result_nxt;
	logic [DATA_W-1:0] store_reg, store_nxt;
	regbits_t wsel_reg, wsel_nxt;
	logic wen_reg, wen_nxt;
	logic dren_reg, dren_nxt;
	logic dwen_reg, dwen_nxt;
	logic halt_reg, halt_nxt;

	always_comb begin
		// hold by default
		result_nxt = result_reg;
		store_nxt = store_reg;
		wsel_nxt = wsel_reg;
		wen_nxt = wen_reg;
		dren_nxt = dren_reg;
		dwen_nxt = dwen_reg;
		halt_nxt = halt_reg;
		if (enable && !flush) begin
			result_nxt = result;
			store_nxt = store_data;
			wsel_nxt = wsel;
			wen_nxt = ex_wen;
			dren_nxt = ex_dren;
			dwen_nxt = ex_dwen;
			halt_nxt = ex_halt;
		end else if (enable) begin
			// flushed slot becomes a bubble
			result_nxt = '0;
			store_nxt = '0;
			wsel_nxt = '0;
			wen_nxt = 1'b0;
			dren_nxt = 1'b0;
			dwen_nxt = 1'b0;
			halt_nxt = 1'b0;
		end
	end

	always_ff @(posedge CLK, negedge nRST) begin
		if (!nRST) begin
			result_reg <= '0;
			store_reg <= '0;
			wsel_reg <= '0;
			wen_reg <= 1'b0;
			dren_reg <= 1'b0;
			dwen_reg <= 1'b0;
			halt_reg <= 1'b0;
		end else begin
			result_reg <= result_nxt;
			store_reg <= store_nxt;
			wsel_reg <= wsel_nxt;
			wen_reg <= wen_nxt;
			dren_reg <= dren_nxt;
			dwen_reg <= dwen_nxt;
			halt_reg <= halt_nxt;
		end
	end

	// address and result are the same ALU value
	assign dmemaddr = result_reg;
	assign result_ex_mem = result_reg;
	assign dmemstore = store_reg;
	assign wsel_ex_mem = wsel_reg;
	assign wen_ex_mem = wen_reg;
	assign dren = dren_reg;
	assign dwen = dwen_reg;
	assign halt_ex_mem = halt_reg;

endmodule

/* ex_stage.sv */
// ============================
// execute stage
// decodes the instruction word, drives the ALU and picks the
// write register; all outputs go straight into EX/MEM
// ============================

`timescale 1ns/1ps

module ex_stage
	import cpu_pkg::*;
#(
	parameter int DATA_W = 32
) (
	input instr_u instr,
	input logic [DATA_W-1:0] rdat1,
	input logic [DATA_W-1:0] rdat2,
	input logic wen,
	input logic halt,
	output logic [DATA_W-1:0] result,
	output logic [DATA_W-1:0] store_data,
	output regbits_t wsel,
	output logic ex_wen,
	output logic ex_dren,
	output logic ex_dwen,
	output logic ex_halt
);

	aluop_t alu_op;
	reg_dest_sel_t reg_dest;
	logic [DATA_W-1:0] imm_ext;
	logic [DATA_W-1:0] alu_b;
	logic valid;

	always_comb begin
		alu_op = ALU_ADD;
		reg_dest = SEL_RD;
		imm_ext = {{(DATA_W-16){instr.itype.imm16[15]}}, instr.itype.imm16};
		valid = 1'b1;
		ex_dren = 1'b0;
		ex_dwen = 1'b0;
		case (instr.rtype.opcode)
			OP_RTYPE: begin
				case (instr.rtype.funct)
					FN_SLL:  alu_op = ALU_SLL;
					FN_ADDU: alu_op = ALU_ADD;
					FN_SUBU: alu_op = ALU_SUB;
					FN_AND:  alu_op = ALU_AND;
					FN_OR:   alu_op = ALU_OR;
					FN_XOR:  alu_op = ALU_XOR;
					FN_SLT:  alu_op = ALU_SLT;
					default: valid = 1'b0;
				endcase
			end
			OP_ADDIU: reg_dest = SEL_RT;
			OP_SLTI: begin
				alu_op = ALU_SLT;
				reg_dest = SEL_RT;
			end
			OP_ORI: begin
				// logical immediate is zero extended
				alu_op = ALU_OR;
				reg_dest = SEL_RT;
				imm_ext = {{(DATA_W-16){1'b0}}, instr.itype.imm16};
			end
			OP_LUI: begin
				alu_op = ALU_LUI;
				reg_dest = SEL_RT;
			end
			OP_LW: begin
				reg_dest = SEL_RT;
				ex_dren = 1'b1;
			end
			OP_SW: begin
				reg_dest = SEL_RT;
				ex_dwen = 1'b1;
			end
			default: valid = 1'b0;
		endcase
	end

	// I-type uses the immediate as second operand
	assign alu_b = (reg_dest == SEL_RT) ? imm_ext : rdat2;

	alu #(
		.DATA_W(DATA_W)
	) alu_i (
		.op(alu_op),
		.a(rdat1),
		.b(alu_b),
		.shamt(instr.rtype.shamt),
		.result(result),
		.zero()
	);

	assign wsel = (reg_dest == SEL_RT) ? instr.itype.rt : instr.rtype.rd;
	assign store_data = rdat2;
	// stores and undecoded words never write the register file
	assign ex_wen = wen & valid & ~ex_dwen;
	assign ex_halt = halt;

endmodule

/* ex_wb_pipe.sv */
// ============================
// top of the execute-to-writeback pipeline slice
// operands arrive already read; results leave on the wb_* outputs
// and data memory sits behind the Wishbone master port
// ============================

`timescale 1ns/1ps

module ex_wb_pipe
	import cpu_pkg::*;
#(
	parameter int DATA_W = 32
) (
	input logic CLK,
	input logic nRST,
	input instr_u instr,
	input logic [DATA_W-1:0] rdat1,
	input logic [DATA_W-1:0] rdat2,
	input logic wen,
	input logic halt,
	input logic flush,
	output logic stall,
	output logic wb_wen,
	output regbits_t wb_addr,
	output logic [DATA_W-1:0] wb_data,
	output logic wb_halt,
	output logic wb_cyc,
	output logic wb_stb,
	output logic wb_we,
	output logic [DATA_W-1:0] wb_adr,
	output logic [DATA_W-1:0] wb_dat_w,
	output logic [DATA_W/8-1:0] wb_sel,
	input logic [DATA_W-1:0] wb_dat_r,
	input logic wb_ack
);

	logic enable;
	// execute outputs
	logic [DATA_W-1:0] ex_result, ex_store;
	regbits_t ex_wsel;
	logic ex_wen, ex_dren, ex_dwen, ex_halt;
	// EX/MEM outputs
	logic [DATA_W-1:0] dmemaddr, dmemstore, result_ex_mem;
	regbits_t wsel_ex_mem;
	logic wen_ex_mem, dren, dwen, halt_ex_mem;
	logic [DATA_W-1:0] load_data;

	// both pipeline registers advance together
	assign enable = ~stall;

	ex_stage #(
		.DATA_W(DATA_W)
	) ex_stage_i (
		.instr(instr),
		.rdat1(rdat1),
		.rdat2(rdat2),
		.wen(wen),
		.halt(halt),
		.result(ex_result),
		.store_data(ex_store),
		.wsel(ex_wsel),
		.ex_wen(ex_wen),
		.ex_dren(ex_dren),
		.ex_dwen(ex_dwen),
		.ex_halt(ex_halt)
	);

	ex_mem_reg #(
		.DATA_W(DATA_W)
	) ex_mem_reg_i (
		.CLK(CLK),
		.nRST(nRST),
		.enable(enable),
		.flush(flush),
		.result(ex_result),
		.store_data(ex_store),
		.wsel(ex_wsel),
		.ex_wen(ex_wen),
		.ex_dren(ex_dren),
		.ex_dwen(ex_dwen),
		.ex_halt(ex_halt),
		.dmemaddr(dmemaddr),
		.dmemstore(dmemstore),
		.result_ex_mem(result_ex_mem),
		.wsel_ex_mem(wsel_ex_mem),
		.wen_ex_mem(wen_ex_mem),
		.dren(dren),
		.dwen(dwen),
		.halt_ex_mem(halt_ex_mem)
	);

	mem_stage #(
		.DATA_W(DATA_W)
	) mem_stage_i (
		.CLK(CLK),
		.nRST(nRST),
		.dmemaddr(dmemaddr),
		.dmemstore(dmemstore),
		.dren(dren),
		.dwen(dwen),
		.wb_dat_r(wb_dat_r),
		.wb_ack(wb_ack),
		.wb_cyc(wb_cyc),
		.wb_stb(wb_stb),
		.wb_we(wb_we),
		.wb_adr(wb_adr),
		.wb_dat_w(wb_dat_w),
		.wb_sel(wb_sel),
		.stall(stall),
		.load_data(load_data)
	);

	mem_wb_reg #(
		.DATA_W(DATA_W)
	) mem_wb_reg_i (
		.CLK(CLK),
		.nRST(nRST),
		.enable(enable),
		.result_ex_mem(result_ex_mem),
		.load_data(load_data),
		.dren(dren),
		.wsel_ex_mem(wsel_ex_mem),
		.wen_ex_mem(wen_ex_mem),
		.halt_ex_mem(halt_ex_mem),
		.wb_wen(wb_wen),
		.wb_addr(wb_addr),
		.wb_data(wb_data),
		.wb_halt(wb_halt)
	);

endmodule

/* ex_wb_pipe_assertions.sv */
// ==============================
// concurrent checks of the Wishbone master and stall rules
// bound into ex_wb_pipe by the testbench
// ==============================

`timescale 1ns/1ps

module ex_wb_pipe_assertions #(
	parameter int DATA_W = 32
) (
	input logic CLK,
	input logic nRST,
	input logic wb_cyc,
	input logic wb_stb,
	input logic wb_we,
	input logic wb_ack,
	input logic [DATA_W-1:0] wb_adr,
	input logic [DATA_W-1:0] wb_dat_w,
	input logic stall
);

	// failures seen so far
	int fail_count = 0;

	stb_needs_cyc: assert property (
		@(posedge CLK) disable iff (!nRST) wb_stb |-> wb_cyc
	) else begin
		$error("wb_stb high without wb_cyc");
		fail_count++;
	end

	// request held unchanged until the slave acks
	request_stable: assert property (
		@(posedge CLK) disable iff (!nRST)
		(wb_stb && !wb_ack) |=> ($stable(wb_adr) && $stable(wb_dat_w) && $stable(wb_we))
	) else begin
		$error("address, data or we changed before ack");
		fail_count++;
	end

	stall_rule: assert property (
		@(posedge CLK) disable iff (!nRST) stall == (wb_cyc && !wb_ack)
	) else begin
		$error("stall differs from cyc and not ack");
		fail_count++;
	end

	bus_idle_in_reset: assert property (
		@(posedge CLK) !nRST |-> (!wb_cyc && !wb_stb)
	) else begin
		$error("bus cycle during reset");
		fail_count++;
	end

endmodule

/* mem_stage.sv */
// ============================
// memory stage, Wishbone classic master
// one single-word transfer per load or store held in EX/MEM;
// stall holds the pipe until the slave acks
// ============================

`timescale 1ns/1ps

module mem_stage #(
	parameter int DATA_W = 32
) (
	input logic CLK,
	input logic nRST,
	input logic [DATA_W-1:0] dmemaddr,
	input logic [DATA_W-1:0] dmemstore,
	input logic dren,
	input logic dwen,
	input logic [DATA_W-1:0] wb_dat_r,
	input logic wb_ack,
	output logic wb_cyc,
	output logic wb_stb,
	output logic wb_we,
	output logic [DATA_W-1:0] wb_adr,
	output logic [DATA_W-1:0] wb_dat_w,
	output logic [DATA_W/8-1:0] wb_sel,
	output logic stall,
	output logic [DATA_W-1:0] load_data
);

	assign wb_cyc = dren | dwen;
	assign wb_stb = dren | dwen;
	assign wb_we = dwen;
	assign wb_adr = dmemaddr;
	assign wb_dat_w = dmemstore;
	assign wb_sel = '1;
	assign stall = wb_cyc & ~wb_ack;
	assign load_data = wb_dat_r;

endmodule

/* mem_wb_reg.sv */
// ============================
// MEM/WB pipeline register
// captures the writeback fields when enabled, with load data
// chosen over the ALU result for loads
// ============================

`timescale 1ns/1ps

module mem_wb_reg
	import cpu_pkg::*;
#(
	parameter int DATA_W = 32
) (
	input logic CLK,
	input logic nRST,
	input logic enable,
	input logic [DATA_W-1:0] result_ex_mem,
	input logic [DATA_W-1:0] load_data,
	input logic dren,
	input regbits_t wsel_ex_mem,
	input logic wen_ex_mem,
	input logic halt_ex_mem,
	output logic wb_wen,
	output regbits_t wb_addr,
	output logic [DATA_W-1:0] wb_data,
	output logic wb_halt
);

	logic [DATA_W-1:0] wdat;

	// loads write back what the bus returned
	assign wdat = dren ? load_data : result_ex_mem;

	always_ff @(posedge CLK, negedge nRST) begin
		if (!nRST) begin
			wb_wen <= 1'b0;
			wb_halt <= 1'b0;
			wb_addr <= '0;
			wb_data <= '0;
		end else if (enable) begin
			wb_wen <= wen_ex_mem;
			wb_halt <= halt_ex_mem;
			wb_addr <= wsel_ex_mem;
			wb_data <= wdat;
		end
	end

endmodule

/* tb_ex_wb_pipe.sv */
// ==============================
// testbench for the EX-to-WB pipeline slice
// applies a table of instructions, answers bus cycles from a
// Wishbone memory model with random wait states and checks
// every writeback slot in order
// ==============================

`timescale 1ns/1ps

module tb_ex_wb_pipe
	import cpu_pkg::*;
();

	typedef struct {
		string name;
		instr_u instr;
		word_t rdat1;
		word_t rdat2;
		logic wen;
		logic halt;
		logic flush;
		logic exp_wen;
		logic exp_halt;
		regbits_t exp_addr;
		word_t exp_data;
	} test_t;

	logic CLK;
	logic nRST;
	instr_u instr;
	word_t rdat1, rdat2;
	logic wen, halt, flush;
	logic stall, wb_wen, wb_halt;
	regbits_t wb_addr;
	word_t wb_data;
	logic wb_cyc, wb_stb, wb_we;
	logic wb_ack = 1'b0;
	word_t wb_adr, wb_dat_w;
	word_t wb_dat_r = '0;
	logic [3:0] wb_sel;

	test_t tests[$];
	// slot indices in acceptance order, -1 is an idle slot
	int slots[$];
	int drv_idx = -1;
	logic accept = 1'b0;
	logic table_built = 1'b0;
	int errors = 0;
	int checks = 0;
	int checked = 0;

	// memory model state
	word_t mem [0:63];
	logic [31:0] lfsr = 32'h2862_0b00;
	logic busy;
	logic [1:0] wait_left;

	ex_wb_pipe #(
		.DATA_W(32)
	) ex_wb_pipe_i (.*);

	bind ex_wb_pipe ex_wb_pipe_assertions #(
		.DATA_W(DATA_W)
	) assertions_i (
		.CLK(CLK),
		.nRST(nRST),
		.wb_cyc(wb_cyc),
		.wb_stb(wb_stb),
		.wb_we(wb_we),
		.wb_ack(wb_ack),
		.wb_adr(wb_adr),
		.wb_dat_w(wb_dat_w),
		.stall(stall)
	);

	initial CLK = 1'b0;
	always #4 CLK = ~CLK;

	// Galois LFSR, one step per random bit taken
	function automatic logic [1:0] next_delay();
		logic [1:0] d;
		int k;
		d = 2'd0;
		for (k = 0; k < 2; k++) begin
			d = {d[0], lfsr[0]};
			lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
		end
		return d;
	endfunction

	function automatic word_t fill_word(input logic [5:0] k);
		return ({26'd0, k} * 32'h0104_1041) ^ 32'h5aa5_0000;
	endfunction

	function automatic instr_u r_word(input funct_t fn, input regbits_t rd, input logic [4:0] sh);
		instr_u w;
		w.rtype.opcode = OP_RTYPE;
		w.rtype.rs = 5'd1;
		w.rtype.rt = 5'd2;
		w.rtype.rd = rd;
		w.rtype.shamt = sh;
		w.rtype.funct = fn;
		return w;
	endfunction

	function automatic instr_u i_word(input opcode_t op, input regbits_t rt, input logic [15:0] imm);
		instr_u w;
		w.itype.opcode = op;
		w.itype.rs = 5'd1;
		w.itype.rt = rt;
		w.itype.imm16 = imm;
		return w;
	endfunction

	task automatic add_test(input string name, input instr_u ins,
		input word_t a, input word_t b, input logic wen_i, input logic halt_i,
		input logic flush_i, input word_t exp_data);
		test_t t;
		t.name = name;
		t.instr = ins;
		t.rdat1 = a;
		t.rdat2 = b;
		t.wen = wen_i;
		t.halt = halt_i;
		t.flush = flush_i;
		// stores and flushed slots never write back
		t.exp_wen = wen_i && !flush_i && ins.itype.opcode != OP_SW;
		t.exp_halt = halt_i && !flush_i;
		t.exp_addr = (ins.rtype.opcode == OP_RTYPE) ? ins.rtype.rd : ins.itype.rt;
		t.exp_data = exp_data;
		tests.push_back(t);
	endtask

	task automatic build_table();
		word_t a;
		word_t b;
		word_t addr;
		logic [15:0] imm;
		a = 32'h0000_1234;
		b = 32'h0000_0ff0;
		add_test("addu", r_word(FN_ADDU, 5'd3, 5'd0), a, b, 1'b1, 1'b0, 1'b0, a + b);
		a = 32'h0000_0005;
		b = 32'h0000_0009;
		add_test("subu", r_word(FN_SUBU, 5'd4, 5'd0), a, b, 1'b1, 1'b0, 1'b0, a - b);
		a = 32'hf0f0_1234;
		b = 32'h3c3c_ff00;
		add_test("and", r_word(FN_AND, 5'd5, 5'd0), a, b, 1'b1, 1'b0, 1'b0, a & b);
		add_test("or", r_word(FN_OR, 5'd6, 5'd0), a, b, 1'b1, 1'b0, 1'b0, a | b);
		add_test("xor", r_word(FN_XOR, 5'd7, 5'd0), a, b, 1'b1, 1'b0, 1'b0, a ^ b);
		a = 32'hffff_fff0;
		b = 32'h0000_0005;
		add_test("slt", r_word(FN_SLT, 5'd8, 5'd0), a, b, 1'b1, 1'b0, 1'b0,
			{31'd0, $signed(a) < $signed(b)});
		b = 32'h8000_00f1;
		add_test("sll", r_word(FN_SLL, 5'd9, 5'd4), a, b, 1'b1, 1'b0, 1'b0, b << 4);
		// immediates, sign extended except for ori
		a = 32'd100;
		imm = 16'hfffe;
		add_test("addiu", i_word(OP_ADDIU, 5'd10, imm), a, 32'd0, 1'b1, 1'b0, 1'b0,
			a + {{16{imm[15]}}, imm});
		a = 32'hffff_fffd;
		imm = 16'h0004;
		add_test("slti", i_word(OP_SLTI, 5'd11, imm), a, 32'd0, 1'b1, 1'b0, 1'b0,
			{31'd0, $signed(a) < $signed({{16{imm[15]}}, imm})});
		a = 32'h1234_0000;
		imm = 16'h8001;
		add_test("ori", i_word(OP_ORI, 5'd12, imm), a, 32'd0, 1'b1, 1'b0, 1'b0,
			a | {16'd0, imm});
		imm = 16'hbeef;
		add_test("lui", i_word(OP_LUI, 5'd13, imm), a, 32'd0, 1'b1, 1'b0, 1'b0, {imm, 16'd0});
		// store then load the same word
		a = 32'h0000_0040;
		b = 32'hcafe_f00d;
		imm = 16'h0008;
		add_test("sw", i_word(OP_SW, 5'd2, imm), a, b, 1'b1, 1'b0, 1'b0, 32'd0);
		add_test("lw", i_word(OP_LW, 5'd14, imm), a, 32'd0, 1'b1, 1'b0, 1'b0, b);
		a = 32'h0000_0011;
		b = 32'h0000_0022;
		add_test("addu after lw", r_word(FN_ADDU, 5'd15, 5'd0), a, b, 1'b1, 1'b0, 1'b0, a + b);
		add_test("flushed addu", r_word(FN_ADDU, 5'd16, 5'd0), a, b, 1'b1, 1'b0, 1'b1, a + b);
		add_test("halt or", r_word(FN_OR, 5'd17, 5'd0), a, b, 1'b1, 1'b1, 1'b0, a | b);
		// an untouched word returns the fill pattern
		a = 32'h0000_0080;
		imm = 16'h0010;
		addr = a + {16'd0, imm};
		add_test("lw fill", i_word(OP_LW, 5'd18, imm), a, 32'd0, 1'b1, 1'b0, 1'b0,
			fill_word(addr[7:2]));
		// negative offsets from two bases reach the same word
		imm = 16'hfff0;
		b = 32'h1357_9bdf;
		add_test("sw neg", i_word(OP_SW, 5'd2, imm), a, b, 1'b1, 1'b0, 1'b0, 32'd0);
		a = 32'h0000_00a0;
		imm = 16'hffd0;
		add_test("lw neg", i_word(OP_LW, 5'd19, imm), a, 32'd0, 1'b1, 1'b0, 1'b0, b);
		add_test("xor after lw", r_word(FN_XOR, 5'd20, 5'd0), a, b, 1'b1, 1'b0, 1'b0, a ^ b);
	endtask

	task automatic compare(input string name, input string field,
		input logic [31:0] expected, input logic [31:0] actual);
		checks++;
		if (expected !== actual) begin
			errors++;
			$display("ERROR %s %s: expected %h, actual %h", name, field, expected, actual);
		end
	endtask

	task automatic check_slot(input int idx);
		test_t t;
		if (idx < 0) begin
			compare("idle", "wb_wen", 32'd0, 32'(wb_wen));
			compare("idle", "wb_halt", 32'd0, 32'(wb_halt));
		end else begin
			t = tests[idx];
			compare(t.name, "wb_wen", 32'(t.exp_wen), 32'(wb_wen));
			compare(t.name, "wb_halt", 32'(t.exp_halt), 32'(wb_halt));
			if (t.exp_wen) begin
				compare(t.name, "wb_addr", 32'(t.exp_addr), 32'(wb_addr));
				compare(t.name, "wb_data", t.exp_data, wb_data);
			end
			checked++;
		end
	endtask

	task automatic apply(input int idx);
		if (idx < 0) begin
			instr <= '0;
			rdat1 <= '0;
			rdat2 <= '0;
			wen <= 1'b0;
			halt <= 1'b0;
			flush <= 1'b0;
		end else begin
			instr <= tests[idx].instr;
			rdat1 <= tests[idx].rdat1;
			rdat2 <= tests[idx].rdat2;
			wen <= tests[idx].wen;
			halt <= tests[idx].halt;
			flush <= tests[idx].flush;
		end
		drv_idx <= idx;
	endtask

	// Wishbone slave, 64 words, 0 to 3 random wait cycles
	always @(posedge CLK or negedge nRST) begin : memory
		int k;
		test_t t;
		if (!nRST) begin
			wb_ack <= 1'b0;
			wb_dat_r <= '0;
			busy <= 1'b0;
			wait_left <= 2'd0;
			for (k = 0; k < 64; k++)
				mem[k] <= fill_word(6'(k));
		end else if (wb_ack) begin
			// transfer completed at this edge
			wb_ack <= 1'b0;
		end else if (wb_cyc && wb_stb) begin
			if (!busy) begin
				busy <= 1'b1;
				wait_left <= next_delay();
			end else if (wait_left != 2'd0) begin
				wait_left <= wait_left - 2'd1;
			end else begin
				busy <= 1'b0;
				wb_ack <= 1'b1;
				wb_dat_r <= mem[wb_adr[7:2]];
				// EX/MEM holds the entry accepted last
				t = tests[slots[slots.size() - 1]];
				compare(t.name, "wb_we", 32'(t.instr.itype.opcode == OP_SW), 32'(wb_we));
				compare(t.name, "wb_sel", 32'h0000_000f, 32'(wb_sel));
				if (wb_we)
					mem[wb_adr[7:2]] <= wb_dat_w;
			end
		end
	end

	// stall is stable here and decides the coming edge
	always @(negedge CLK)
		accept <= nRST && !stall;

	initial begin : monitor
		int idx;
		forever begin
			@(posedge CLK);
			if (accept) begin
				slots.push_back(drv_idx);
				if (slots.size() > 1) begin
					idx = slots.pop_front();
					@(negedge CLK);
					check_slot(idx);
				end
			end
		end
	end

	initial begin : watchdog
		while (!table_built)
			@(posedge CLK);
		repeat (tests.size() * 10 + 50) @(posedge CLK);
		$display("timeout: not every table entry reached writeback in time");
		$display("tests failed");
		$finish;
	end

	initial begin : main
		int i;
		int afail;
		nRST = 1'b0;
		instr = '0;
		rdat1 = '0;
		rdat2 = '0;
		wen = 1'b0;
		halt = 1'b0;
		flush = 1'b0;
		build_table();
		table_built = 1'b1;
		repeat (7) @(posedge CLK);
		@(negedge CLK);
		compare("reset", "wb_wen", 32'd0, 32'(wb_wen));
		compare("reset", "wb_halt", 32'd0, 32'(wb_halt));
		compare("reset", "wb_cyc", 32'd0, 32'(wb_cyc));
		compare("reset", "stall", 32'd0, 32'(stall));
		@(posedge CLK);
		nRST <= 1'b1;
		@(posedge CLK);
		apply(0);
		// next entry goes out on the edge that took the current one
		for (i = 1; i <= tests.size(); i++) begin
			do
				@(posedge CLK);
			while (!accept);
			if (i < tests.size())
				apply(i);
			else
				apply(-1);
		end
		while (checked < tests.size())
			@(posedge CLK);
		repeat (2) @(posedge CLK);
		afail = ex_wb_pipe_i.assertions_i.fail_count;
		$display("checks: %0d, value errors: %0d, assertion failures: %0d",
			checks, errors, afail);
		if (errors == 0 && afail == 0) begin
			$display("all tests passed");
		end else begin
			$display("tests failed");
		end
		$finish;
	end

endmodule
